/* hw/exec_params.svh */
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

`define EXEC_DATA_W     16
`define EXEC_REG_COUNT  64
`define EXEC_REG_W      6
`define EXEC_OP_W       6

// operation numbers
`define EXEC_OP_NOP     6'd0
`define EXEC_OP_ADD     6'd1   // mode adds carry-in, writes carry
`define EXEC_OP_SUB     6'd2   // mode subtracts borrow-in, writes carry
`define EXEC_OP_AND     6'd3   // mode selects immediate operand
`define EXEC_OP_OR      6'd4
`define EXEC_OP_XOR     6'd5
`define EXEC_OP_ASR     6'd6
`define EXEC_OP_SHL     6'd7
`define EXEC_OP_SHR     6'd8
`define EXEC_OP_MOV     6'd9
`define EXEC_OP_ADDI    6'd10
`define EXEC_OP_SUBI    6'd11
`define EXEC_OP_ASRI    6'd12
`define EXEC_OP_SHLI    6'd13
`define EXEC_OP_SHRI    6'd14
`define EXEC_OP_MOVI    6'd15
`define EXEC_OP_BR      6'd32
`define EXEC_OP_BEQ     6'd34
`define EXEC_OP_BNE     6'd35
`define EXEC_OP_BLT     6'd36
`define EXEC_OP_BGT     6'd37
`define EXEC_OP_BLTU    6'd38
`define EXEC_OP_BGTU    6'd39

`endif

/* hw/exec_pkg.sv */
`include "exec_params.svh"

package exec_pkg;

	// instruction as accepted on the input port
	typedef struct packed {
		logic [`EXEC_OP_W-1:0]   op;
		logic                    mode;   // carry / immediate select
		logic [`EXEC_REG_W-1:0]  dst;
		logic [`EXEC_REG_W-1:0]  src1;
		logic [`EXEC_REG_W-1:0]  src2;
		logic [`EXEC_DATA_W-1:0] imm;
	} instr_t;

	// one result per instruction
	typedef struct packed {
		logic                    wr_en;
		logic [`EXEC_REG_W-1:0]  wr_addr;
		logic [`EXEC_DATA_W-1:0] wr_data;
		logic                    carry_en;
		logic                    carry;
		logic                    taken;
		logic [`EXEC_DATA_W-1:0] pc_change;   // signed offset
	} result_t;

	// instruction plus fetched values
	typedef struct packed {
		instr_t                  instr;
		logic [`EXEC_DATA_W-1:0] a;           // src1 value
		logic [`EXEC_DATA_W-1:0] b;           // src2 value or immediate
		logic                    carry_in;
	} operands_t;

endpackage

/* hw/reg_file.sv */
`timescale 1ns/100ps
`include "exec_params.svh"

module reg_file (
	input  logic                    clock,
	input  logic                    rst_n,
	input  logic [`EXEC_REG_W-1:0]  rd_addr_a,
	input  logic [`EXEC_REG_W-1:0]  rd_addr_b,
	output logic [`EXEC_DATA_W-1:0] rd_data_a,
	output logic [`EXEC_DATA_W-1:0] rd_data_b,
	output logic                    carry,
	input  logic                    wr_en,
	input  logic [`EXEC_REG_W-1:0]  wr_addr,
	input  logic [`EXEC_DATA_W-1:0] wr_data,
	input  logic                    carry_en,
	input  logic                    carry_in
);

	logic [`EXEC_DATA_W-1:0] regs [`EXEC_REG_COUNT];

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int i = 0; i < `EXEC_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
			carry <= 1'b0;
		end else begin
			if (wr_en) begin
				regs[wr_addr] <= wr_data;
			end
			if (carry_en) begin
				carry <= carry_in;
			end
		end
	end

	assign rd_data_a = regs[rd_addr_a];   // async read
	assign rd_data_b = regs[rd_addr_b];

endmodule

/* hw/pipe_stage.sv */
`timescale 1ns/100ps

module pipe_stage #(
	parameter type payload_t = logic
) (
	input  logic     clock,
	input  logic     rst_n,
	input  logic     in_valid,
	output logic     in_ready,
	input  payload_t in_data,
	output logic     out_valid,
	input  logic     out_ready,
	output payload_t out_data
);

	logic load;

	// free slot or slot drains this edge
	assign in_ready = !out_valid || out_ready;
	assign load = in_valid && in_ready;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else if (load) begin
			out_valid <= 1'b1;
		end else if (out_ready) begin
			out_valid <= 1'b0;   // handed off, nothing new
		end
	end

	always_ff @(posedge clock) begin
		if (load) begin
			out_data <= in_data;
		end
	end

endmodule

/* hw/operand_fetch.sv */
`timescale 1ns/100ps
`include "exec_params.svh"

module operand_fetch
	import exec_pkg::*;
(
	input  instr_t                  instr,
	output logic [`EXEC_REG_W-1:0]  rd_addr_a,
	output logic [`EXEC_REG_W-1:0]  rd_addr_b,
	input  logic [`EXEC_DATA_W-1:0] rd_data_a,
	input  logic [`EXEC_DATA_W-1:0] rd_data_b,
	input  logic                    carry,
	input  logic                    pend_valid,
	input  result_t                 pend,
	output operands_t               ops
);

	logic imm_form;
	logic fwd_a;
	logic fwd_b;
	logic fwd_carry;

	assign rd_addr_a = instr.src1;
	assign rd_addr_b = instr.src2;

	// 10..15 always, logic ops only with mode
	assign imm_form = (instr.op >= `EXEC_OP_ADDI && instr.op <= `EXEC_OP_MOVI) ||
		(instr.mode && instr.op >= `EXEC_OP_AND && instr.op <= `EXEC_OP_XOR);

	// the result waiting in retire is not yet in the register file
	assign fwd_a = pend_valid && pend.wr_en && (pend.wr_addr == instr.src1);
	assign fwd_b = pend_valid && pend.wr_en && (pend.wr_addr == instr.src2);
	assign fwd_carry = pend_valid && pend.carry_en;

	always_comb begin
		ops.instr = instr;
		ops.a = fwd_a ? pend.wr_data : rd_data_a;
		if (imm_form) begin
			ops.b = instr.imm;
		end else begin
			ops.b = fwd_b ? pend.wr_data : rd_data_b;
		end
		ops.carry_in = fwd_carry ? pend.carry : carry;
	end

endmodule

/* hw/alu.sv */
`timescale 1ns/100ps
`include "exec_params.svh"

module alu
	import exec_pkg::*;
(
	input  operands_t               ops,
	output logic                    wr_en,
	output logic [`EXEC_DATA_W-1:0] wr_data,
	output logic                    carry_en,
	output logic                    carry
);

	logic [`EXEC_DATA_W-1:0]   a;
	logic [`EXEC_DATA_W-1:0]   b;
	logic [4:0]                amt;
	logic [`EXEC_DATA_W:0]     cin_ext;
	logic [`EXEC_DATA_W:0]     sum;
	logic [`EXEC_DATA_W:0]     diff;
	logic [2*`EXEC_DATA_W-1:0] shl_wide;
	logic [2*`EXEC_DATA_W-1:0] shr_wide;
	logic [2*`EXEC_DATA_W-1:0] asr_wide;

	assign a = ops.a;
	assign b = ops.b;
	assign amt = b[4:0];   // 16..31 flush everything out
	assign cin_ext = {{`EXEC_DATA_W{1'b0}}, ops.instr.mode & ops.carry_in};

	assign sum = {1'b0, a} + {1'b0, b} + cin_ext;
	assign diff = {1'b0, a} - {1'b0, b} - cin_ext;   // bit 16 is the borrow

	// shift in a double-width window so the bits pushed out stay visible
	assign shl_wide = {{`EXEC_DATA_W{1'b0}}, a} << amt;
	assign shr_wide = {a, {`EXEC_DATA_W{1'b0}}} >> amt;
	assign asr_wide = $signed({a, {`EXEC_DATA_W{1'b0}}}) >>> amt;

	always_comb begin
		wr_en = 1'b1;
		wr_data = '0;
		carry_en = 1'b0;
		carry = 1'b0;
		case (ops.instr.op)
			`EXEC_OP_NOP: wr_en = 1'b0;
			`EXEC_OP_ADD: begin
				wr_data = sum[`EXEC_DATA_W-1:0];
				if (ops.instr.mode) begin
					carry_en = 1'b1;
					carry = sum[`EXEC_DATA_W];
				end
			end
			`EXEC_OP_SUB: begin
				wr_data = diff[`EXEC_DATA_W-1:0];
				if (ops.instr.mode) begin
					carry_en = 1'b1;
					carry = diff[`EXEC_DATA_W];
				end
			end
			`EXEC_OP_AND: wr_data = a & b;
			`EXEC_OP_OR:  wr_data = a | b;
			`EXEC_OP_XOR: wr_data = a ^ b;
			`EXEC_OP_ASR, `EXEC_OP_ASRI: begin
				wr_data = asr_wide[2*`EXEC_DATA_W-1:`EXEC_DATA_W];   // sign fill
			end
			`EXEC_OP_SHL: begin
				wr_data = shl_wide[`EXEC_DATA_W-1:0];
				carry_en = 1'b1;
				carry = shl_wide[`EXEC_DATA_W];   // last bit out of the top
			end
			`EXEC_OP_SHR: begin
				wr_data = shr_wide[2*`EXEC_DATA_W-1:`EXEC_DATA_W];
				carry_en = 1'b1;
				carry = shr_wide[`EXEC_DATA_W-1];   // last bit out of the bottom
			end
			`EXEC_OP_SHLI: wr_data = shl_wide[`EXEC_DATA_W-1:0];
			`EXEC_OP_SHRI: wr_data = shr_wide[2*`EXEC_DATA_W-1:`EXEC_DATA_W];
			`EXEC_OP_MOV:  wr_data = a;
			`EXEC_OP_ADDI: wr_data = a + b;   // no carry involved
			`EXEC_OP_SUBI: wr_data = a - b;
			`EXEC_OP_MOVI: wr_data = b;
			default:       wr_en = 1'b0;   // branches, unknown ops
		endcase
	end

endmodule

/* hw/branch_unit.sv */
`timescale 1ns/100ps
`include "exec_params.svh"

module branch_unit
	import exec_pkg::*;
(
	input  operands_t               ops,
	output logic                    taken,
	output logic [`EXEC_DATA_W-1:0] pc_change
);

	logic [`EXEC_DATA_W-1:0] a;
	logic [`EXEC_DATA_W-1:0] b;

	assign a = ops.a;   // compare register values, not numbers
	assign b = ops.b;

	always_comb begin
		case (ops.instr.op)
			`EXEC_OP_BR:   taken = 1'b1;
			`EXEC_OP_BEQ:  taken = (a == b);
			`EXEC_OP_BNE:  taken = (a != b);
			`EXEC_OP_BLT:  taken = ($signed(a) < $signed(b));
			`EXEC_OP_BGT:  taken = ($signed(a) > $signed(b));
			`EXEC_OP_BLTU: taken = (a < b);
			`EXEC_OP_BGTU: taken = (a > b);
			default:       taken = 1'b0;
		endcase
	end

	assign pc_change = taken ? ops.instr.imm : '0;   // relative offset

endmodule

/* hw/exec_core.sv */
`timescale 1ns/100ps
`include "exec_params.svh"

module exec_core
	import exec_pkg::*;
(
	input  logic                    clock,
	input  logic                    rst_n,
	input  logic                    in_valid,
	output logic                    in_ready,
	input  logic [`EXEC_OP_W-1:0]   in_op,
	input  logic                    in_mode,
	input  logic [`EXEC_REG_W-1:0]  in_dst,
	input  logic [`EXEC_REG_W-1:0]  in_src1,
	input  logic [`EXEC_REG_W-1:0]  in_src2,
	input  logic [`EXEC_DATA_W-1:0] in_imm,
	output logic                    res_valid,
	input  logic                    res_ready,
	output logic                    res_wr_en,
	output logic [`EXEC_REG_W-1:0]  res_wr_addr,
	output logic [`EXEC_DATA_W-1:0] res_wr_data,
	output logic                    res_carry_en,
	output logic                    res_carry,
	output logic                    res_taken,
	output logic [`EXEC_DATA_W-1:0] res_pc_change
);

	instr_t                  in_instr;
	instr_t                  issue_instr;
	logic                    issue_valid;
	logic                    retire_ready;
	operands_t               ops;
	result_t                 exec_res;
	result_t                 retire_res;
	logic [`EXEC_REG_W-1:0]  rd_addr_a;
	logic [`EXEC_REG_W-1:0]  rd_addr_b;
	logic [`EXEC_DATA_W-1:0] rd_data_a;
	logic [`EXEC_DATA_W-1:0] rd_data_b;
	logic                    rf_carry;
	logic                    alu_wr_en;
	logic [`EXEC_DATA_W-1:0] alu_wr_data;
	logic                    alu_carry_en;
	logic                    alu_carry;
	logic                    br_taken;
	logic [`EXEC_DATA_W-1:0] br_pc_change;
	logic                    res_fire;

	assign in_instr = '{op: in_op, mode: in_mode, dst: in_dst, src1: in_src1,
		src2: in_src2, imm: in_imm};

	pipe_stage #(.payload_t(instr_t)) i_issue (
		.clock     (clock),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_data   (in_instr),
		.out_valid (issue_valid),
		.out_ready (retire_ready),
		.out_data  (issue_instr)
	);

	operand_fetch i_operand_fetch (
		.instr      (issue_instr),
		.rd_addr_a  (rd_addr_a),
		.rd_addr_b  (rd_addr_b),
		.rd_data_a  (rd_data_a),
		.rd_data_b  (rd_data_b),
		.carry      (rf_carry),
		.pend_valid (res_valid),   // retire content not yet written back
		.pend       (retire_res),
		.ops        (ops)
	);

	alu i_alu (
		.ops      (ops),
		.wr_en    (alu_wr_en),
		.wr_data  (alu_wr_data),
		.carry_en (alu_carry_en),
		.carry    (alu_carry)
	);

	branch_unit i_branch_unit (
		.ops       (ops),
		.taken     (br_taken),
		.pc_change (br_pc_change)
	);

	assign exec_res = '{wr_en: alu_wr_en, wr_addr: ops.instr.dst, wr_data: alu_wr_data,
		carry_en: alu_carry_en, carry: alu_carry, taken: br_taken,
		pc_change: br_pc_change};

	pipe_stage #(.payload_t(result_t)) i_retire (
		.clock     (clock),
		.rst_n     (rst_n),
		.in_valid  (issue_valid),
		.in_ready  (retire_ready),
		.in_data   (exec_res),
		.out_valid (res_valid),
		.out_ready (res_ready),
		.out_data  (retire_res)
	);

	// write back when the result leaves
	assign res_fire = res_valid && res_ready;

	reg_file i_reg_file (
		.clock     (clock),
		.rst_n     (rst_n),
		.rd_addr_a (rd_addr_a),
		.rd_addr_b (rd_addr_b),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b),
		.carry     (rf_carry),
		.wr_en     (res_fire && retire_res.wr_en),
		.wr_addr   (retire_res.wr_addr),
		.wr_data   (retire_res.wr_data),
		.carry_en  (res_fire && retire_res.carry_en),
		.carry_in  (retire_res.carry)
	);

	assign res_wr_en = retire_res.wr_en;
	assign res_wr_addr = retire_res.wr_addr;
	assign res_wr_data = retire_res.wr_data;
	assign res_carry_en = retire_res.carry_en;
	assign res_carry = retire_res.carry;
	assign res_taken = retire_res.taken;
	assign res_pc_change = retire_res.pc_change;

endmodule

/* verif/tb_exec_model.svh */
`ifndef TB_EXEC_MODEL_SVH
`define TB_EXEC_MODEL_SVH

logic [`EXEC_DATA_W-1:0] model_regs [`EXEC_REG_COUNT];   // state as retired so far
logic                    model_carry;

function automatic void clear_model();
	for (int i = 0; i < `EXEC_REG_COUNT; i++) begin
		model_regs[i] = '0;
	end
	model_carry = 1'b0;
endfunction

// expected result of one instruction; advances the model state
function automatic result_t exec_ref(input instr_t ins);
	result_t                 r;
	logic [`EXEC_DATA_W-1:0] a;
	logic [`EXEC_DATA_W-1:0] b;
	logic [`EXEC_DATA_W:0]   wide;
	logic [4:0]              amt;
	logic                    cin;
	r = '0;
	a = model_regs[ins.src1];
	b = model_regs[ins.src2];
	if ((ins.op >= `EXEC_OP_ADDI && ins.op <= `EXEC_OP_MOVI) ||
		(ins.mode && ins.op >= `EXEC_OP_AND && ins.op <= `EXEC_OP_XOR)) begin
		b = ins.imm;   // immediate forms
	end
	amt = b[4:0];
	cin = ins.mode & model_carry;
	r.wr_en = (ins.op >= `EXEC_OP_ADD && ins.op <= `EXEC_OP_MOVI);
	r.wr_addr = ins.dst;
	case (ins.op)
		`EXEC_OP_ADD: begin
			wide = {1'b0, a} + {1'b0, b} + {16'd0, cin};
			r.wr_data = wide[`EXEC_DATA_W-1:0];
			r.carry_en = ins.mode;
			r.carry = wide[`EXEC_DATA_W];
		end
		`EXEC_OP_SUB: begin
			r.wr_data = a - b - {15'd0, cin};
			r.carry_en = ins.mode;
			r.carry = ({1'b0, a} < {1'b0, b} + {16'd0, cin});   // borrow out
		end
		`EXEC_OP_AND:  r.wr_data = a & b;
		`EXEC_OP_OR:   r.wr_data = a | b;
		`EXEC_OP_XOR:  r.wr_data = a ^ b;
		`EXEC_OP_ASR, `EXEC_OP_ASRI: begin
			r.wr_data = $signed(a) >>> amt;   // past 15 only sign copies remain
		end
		`EXEC_OP_SHL: begin
			r.wr_data = a << amt;
			r.carry_en = 1'b1;
			if (amt != 5'd0 && amt <= 5'd16) begin
				r.carry = a[4'(16 - amt)];
			end
		end
		`EXEC_OP_SHR: begin
			r.wr_data = a >> amt;
			r.carry_en = 1'b1;
			if (amt != 5'd0 && amt <= 5'd16) begin
				r.carry = a[4'(amt - 1)];
			end
		end
		`EXEC_OP_SHLI: r.wr_data = a << amt;
		`EXEC_OP_SHRI: r.wr_data = a >> amt;
		`EXEC_OP_MOV:  r.wr_data = a;
		`EXEC_OP_ADDI: r.wr_data = a + b;
		`EXEC_OP_SUBI: r.wr_data = a - b;
		`EXEC_OP_MOVI: r.wr_data = b;
		`EXEC_OP_BR:   r.taken = 1'b1;
		`EXEC_OP_BEQ:  r.taken = (a == b);
		`EXEC_OP_BNE:  r.taken = (a != b);
		`EXEC_OP_BLT:  r.taken = ($signed(a) < $signed(b));
		`EXEC_OP_BGT:  r.taken = ($signed(a) > $signed(b));
		`EXEC_OP_BLTU: r.taken = (a < b);
		`EXEC_OP_BGTU: r.taken = (a > b);
		default: ;   // nop and unknown ops
	endcase
	r.pc_change = r.taken ? ins.imm : '0;
	if (r.wr_en) begin
		model_regs[ins.dst] = r.wr_data;
	end
	if (r.carry_en) begin
		model_carry = r.carry;
	end
	return r;
endfunction

`endif

/* verif/tb_exec_core.sv */
`timescale 1ns/100ps
`include "exec_params.svh"

module tb_exec_core
	import exec_pkg::*;
();

	localparam int NUM_INSTR = 417;   // all tests together

	logic                    clock;
	logic                    rst_n;
	logic                    in_valid;
	logic                    in_ready;
	logic [`EXEC_OP_W-1:0]   in_op;
	logic                    in_mode;
	logic [`EXEC_REG_W-1:0]  in_dst;
	logic [`EXEC_REG_W-1:0]  in_src1;
	logic [`EXEC_REG_W-1:0]  in_src2;
	logic [`EXEC_DATA_W-1:0] in_imm;
	logic                    res_valid;
	logic                    res_ready;
	logic                    res_wr_en;
	logic [`EXEC_REG_W-1:0]  res_wr_addr;
	logic [`EXEC_DATA_W-1:0] res_wr_data;
	logic                    res_carry_en;
	logic                    res_carry;
	logic                    res_taken;
	logic [`EXEC_DATA_W-1:0] res_pc_change;
	logic                    stall_en;   // random back-pressure on results
	int                      errors;
	int                      err_base;   // errors before the current test
	int                      checks;
	instr_t                  drive_q [$];
	result_t                 exp_q [$];
	string                   name_q [$];

	`include "tb_exec_model.svh"

	exec_core i_dut (
		.clock         (clock),
		.rst_n         (rst_n),
		.in_valid      (in_valid),
		.in_ready      (in_ready),
		.in_op         (in_op),
		.in_mode       (in_mode),
		.in_dst        (in_dst),
		.in_src1       (in_src1),
		.in_src2       (in_src2),
		.in_imm        (in_imm),
		.res_valid     (res_valid),
		.res_ready     (res_ready),
		.res_wr_en     (res_wr_en),
		.res_wr_addr   (res_wr_addr),
		.res_wr_data   (res_wr_data),
		.res_carry_en  (res_carry_en),
		.res_carry     (res_carry),
		.res_taken     (res_taken),
		.res_pc_change (res_pc_change)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("[ERROR] %s expected %h actual %h", name, expected, actual);
		end
	endtask

	// fields without meaning for this result are zeroed before compare
	function automatic result_t mask_unused(input result_t r);
		result_t m;
		m = r;
		if (!m.wr_en) begin
			m.wr_addr = '0;
			m.wr_data = '0;
		end
		if (!m.carry_en) begin
			m.carry = 1'b0;
		end
		return m;
	endfunction

	function automatic void queue_instr(input logic [5:0] op, input logic mode,
		input logic [5:0] dst, input logic [5:0] src1, input logic [5:0] src2,
		input logic [15:0] imm);
		drive_q.push_back(instr_t'{op: op, mode: mode, dst: dst, src1: src1, src2: src2,
			imm: imm});
	endfunction

	// feeds the driver queue, then waits until every result is back
	task automatic run_test(input string name);
		int     n;
		instr_t ins;
		n = drive_q.size();
		while (drive_q.size() > 0) begin
			ins = drive_q.pop_front();
			exp_q.push_back(mask_unused(exec_ref(ins)));
			name_q.push_back($sformatf("%s #%0d", name, n - drive_q.size()));
			in_valid = 1'b1;
			in_op = ins.op;
			in_mode = ins.mode;
			in_dst = ins.dst;
			in_src1 = ins.src1;
			in_src2 = ins.src2;
			in_imm = ins.imm;
			@(posedge clock);
			while (!in_ready) @(posedge clock);
			#1;
			in_valid = 1'b0;
		end
		while (exp_q.size() > 0) @(posedge clock);
		#1;
		$display("test %s: %0d instructions, %0d mismatches", name, n, errors - err_base);
		err_base = errors;
	endtask

	initial begin
		res_ready = 1'b0;
		forever begin
			@(posedge clock);
			#1;
			res_ready = stall_en ? ($urandom % 3 != 0) : 1'b1;
		end
	end

	// one compare per result transfer, in order
	initial begin
		result_t act;
		forever begin
			@(posedge clock);
			if (rst_n && res_valid && res_ready) begin
				act = mask_unused(result_t'{wr_en: res_wr_en, wr_addr: res_wr_addr,
					wr_data: res_wr_data, carry_en: res_carry_en, carry: res_carry,
					taken: res_taken, pc_change: res_pc_change});
				if (exp_q.size() == 0) begin
					errors++;
					$display("result transfer with no instruction outstanding: %h", act);
				end else begin
					check_value(name_q.pop_front(), 64'(exp_q.pop_front()), 64'(act));
				end
			end
		end
	end

	initial begin
		repeat (NUM_INSTR * 40 + 200) @(posedge clock);
		$display("timeout: the DUT stopped accepting instructions or returning results");
		$display("Errors found");
		$finish;
	end

	initial begin
		int          amts [6];
		int unsigned k;
		logic [5:0]  op;
		amts = '{0, 1, 15, 16, 20, 33};   // 33 keeps only its low five bits
		void'($urandom(86452));
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_op = '0;
		in_mode = 1'b0;
		in_dst = '0;
		in_src1 = '0;
		in_src2 = '0;
		in_imm = '0;
		stall_en = 1'b0;
		errors = 0;
		err_base = 0;
		checks = 0;
		clear_model();
		repeat (5) @(posedge clock);
		#1;
		rst_n = 1'b1;
		@(posedge clock);
		#1;

		check_value("reset res_valid", 64'd0, 64'(res_valid));
		check_value("reset in_ready", 64'd1, 64'(in_ready));
		queue_instr(`EXEC_OP_NOP, 1'b0, 6'd1, 6'd2, 6'd3, 16'h1234);
		queue_instr(6'd20, 1'b1, 6'd4, 6'd0, 6'd0, 16'h0042);   // dropped load op
		run_test("reset_nop");

		for (int i = 1; i <= 8; i++) begin
			queue_instr(`EXEC_OP_MOVI, 1'b0, 6'(i), 6'd0, 6'd0, 16'(i * 4951));
		end
		for (int i = 1; i <= 8; i++) begin
			queue_instr(`EXEC_OP_MOV, 1'b0, 6'(i + 8), 6'(9 - i), 6'd0, 16'h0);
		end
		run_test("moves");

		queue_instr(`EXEC_OP_MOVI, 1'b0, 6'd20, 6'd0, 6'd0, 16'hFFFF);
		queue_instr(`EXEC_OP_MOVI, 1'b0, 6'd21, 6'd0, 6'd0, 16'h0001);
		queue_instr(`EXEC_OP_MOVI, 1'b0, 6'd22, 6'd0, 6'd0, 16'h8000);
		queue_instr(`EXEC_OP_ADD, 1'b1, 6'd23, 6'd20, 6'd21, 16'h0);   // carry out
		queue_instr(`EXEC_OP_ADD, 1'b1, 6'd24, 6'd21, 6'd21, 16'h0);   // forwarded carry in
		queue_instr(`EXEC_OP_ADD, 1'b0, 6'd25, 6'd23, 6'd24, 16'h0);
		queue_instr(`EXEC_OP_SUB, 1'b1, 6'd26, 6'd21, 6'd20, 16'h0);   // borrow out
		queue_instr(`EXEC_OP_SUB, 1'b1, 6'd27, 6'd26, 6'd21, 16'h0);
		queue_instr(`EXEC_OP_SUB, 1'b0, 6'd28, 6'd22, 6'd21, 16'h0);
		queue_instr(`EXEC_OP_ADDI, 1'b0, 6'd29, 6'd28, 6'd0, 16'h1234);
		queue_instr(`EXEC_OP_SUBI, 1'b0, 6'd30, 6'd29, 6'd0, 16'h0FFF);
		queue_instr(`EXEC_OP_ADD, 1'b1, 6'd31, 6'd22, 6'd22, 16'h0);
		queue_instr(`EXEC_OP_ADD, 1'b1, 6'd31, 6'd31, 6'd20, 16'h0);
		run_test("add_sub");

		queue_instr(`EXEC_OP_MOVI, 1'b0, 6'd40, 6'd0, 6'd0, 16'hA5C3);
		queue_instr(`EXEC_OP_MOVI, 1'b0, 6'd41, 6'd0, 6'd0, 16'h0F0F);
		queue_instr(`EXEC_OP_AND, 1'b0, 6'd42, 6'd40, 6'd41, 16'h0);
		queue_instr(`EXEC_OP_OR, 1'b0, 6'd43, 6'd40, 6'd41, 16'h0);
		queue_instr(`EXEC_OP_XOR, 1'b0, 6'd44, 6'd40, 6'd41, 16'h0);
		queue_instr(`EXEC_OP_AND, 1'b1, 6'd42, 6'd40, 6'd41, 16'h00FF);
		queue_instr(`EXEC_OP_OR, 1'b1, 6'd43, 6'd40, 6'd41, 16'hF000);
		queue_instr(`EXEC_OP_XOR, 1'b1, 6'd44, 6'd40, 6'd41, 16'hFFFF);
		for (int i = 0; i < 6; i++) begin
			queue_instr(`EXEC_OP_MOVI, 1'b0, 6'd45, 6'd0, 6'd0, 16'(amts[i]));
			queue_instr(`EXEC_OP_ASR, 1'b0, 6'd46, 6'd40, 6'd45, 16'h0);
			queue_instr(`EXEC_OP_SHL, 1'b0, 6'd47, 6'd40, 6'd45, 16'h0);
			queue_instr(`EXEC_OP_SHR, 1'b0, 6'd48, 6'd40, 6'd45, 16'h0);
			queue_instr(`EXEC_OP_ASRI, 1'b0, 6'd49, 6'd41, 6'd0, 16'(amts[i]));
			queue_instr(`EXEC_OP_SHLI, 1'b0, 6'd49, 6'd40, 6'd0, 16'(amts[i]));
			queue_instr(`EXEC_OP_SHRI, 1'b0, 6'd49, 6'd40, 6'd0, 16'(amts[i]));
		end
		run_test("logic_shift");

		queue_instr(`EXEC_OP_MOVI, 1'b0, 6'd50, 6'd0, 6'd0, 16'h0005);
		queue_instr(`EXEC_OP_MOVI, 1'b0, 6'd51, 6'd0, 6'd0, 16'h0003);
		queue_instr(`EXEC_OP_MOVI, 1'b0, 6'd52, 6'd0, 6'd0, 16'h0007);
		queue_instr(`EXEC_OP_MOVI, 1'b0, 6'd53, 6'd0, 6'd0, 16'hFFFE);   // signed -2
		queue_instr(`EXEC_OP_MOVI, 1'b0, 6'd54, 6'd0, 6'd0, 16'h0002);
		queue_instr(`EXEC_OP_BR, 1'b0, 6'd0, 6'd0, 6'd0, 16'hFFF0);
		for (int p = 0; p < 5; p++) begin
			for (int b = 34; b <= 39; b++) begin
				queue_instr(6'(b), 1'b0, 6'd0, 6'(50 + p), 6'(p == 0 ? 50 : 50 + (p ^ 3)),
					16'(32'hFF00 + p * 8 + b));
			end
		end
		run_test("branches");

		stall_en = 1'b1;
		for (int n = 0; n < 300; n++) begin
			k = $urandom % 23;
			if (k < 16) begin
				op = 6'(k);
			end else if (k == 16) begin
				op = `EXEC_OP_BR;
			end else begin
				op = 6'(k + 17);   // 34..39
			end
			queue_instr(op, 1'($urandom % 2), 6'($urandom % 8), 6'($urandom % 8),
				6'($urandom % 8), 16'($urandom));
		end
		run_test("random_stream");
		stall_en = 1'b0;

		$display("tests 6, checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

/* compile.f */
+incdir+hw
+incdir+verif
hw/exec_pkg.sv
hw/reg_file.sv
hw/pipe_stage.sv
hw/operand_fetch.sv
hw/alu.sv
hw/branch_unit.sv
hw/exec_core.sv
verif/tb_exec_core.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, then decide from the log
verilator --binary --timing -f compile.f --top-module tb_exec_core \
	|| { echo "build failed"; exit 1; }
./obj_dir/Vtb_exec_core > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log
grep -q "Errors found" sim.log && exit 1 || exit 0
